// File: tests/mouse_trace.txt
// status dx dy flag exp_x exp_y exp_buttons, all hex
// flag 0 clean, 1 parity flipped on last byte, 2 stray non-sync byte first
08 05 03 0 35 1d 0
39 f6 fe 0 2b 1f 1
0a 10 00 0 3b 1f 2
0c 00 08 0 3b 17 4
08 7f 00 0 5f 17 0
08 00 7f 0 5f 00 0
18 80 00 0 00 00 0
28 00 80 0 00 3f 0
48 7f 05 0 00 3a 0
88 14 7f 0 14 3a 0
c9 40 40 0 14 3a 1
08 10 10 1 14 3a 1
08 03 02 2 17 38 0
3b fd fc 0 14 3c 3
0f 1c 14 0 30 28 7
08 0a 0a 2 3a 1e 0

// File: mouse_oled_top.f
+incdir+common
common/mouse_pkg.sv
ps2/ps2_rx.sv
ps2/mouse_packet.sv
oled/pixel_scan.sv
oled/oled_spi.sv
hw/mouse_oled_top.sv
tests/tb_mouse_oled.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mouse_oled \
  -f mouse_oled_top.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "Regression passed"

// File: tests/tb_mouse_oled.sv
`timescale 1ns/10ps
`include "mouse_consts.svh"

module tb_mouse_oled
  import mouse_pkg::*;
();

  localparam int MAX_PKTS    = 64;
  localparam int COLS        = 7;                        // status dx dy flag x y buttons
  localparam int FRAME_WORDS = `SCREEN_W * `SCREEN_H;
  localparam int WORD_CYCLES = 33;                       // load cycle plus 16 bits of 2 clk
  localparam int PS2_HALF    = 20;                       // 40-cycle ps/2 clock
  localparam int PKT_BUDGET  = 2500;                     // up to 4 bytes of 11 bits, gaps, settle
  localparam int STALL_LIMIT = 200;
  localparam logic [7:0] STRAY_BYTE = 8'h55;             // sync bit clear

  logic    clk;
  logic    arst_n;
  logic    ps2_clk;
  logic    ps2_dat;
  cursor_t cursor;
  logic    oled_csn;
  logic    oled_clk;
  logic    oled_mosi;

  logic [7:0]  trace_mem [0:MAX_PKTS*COLS-1];
  int          n_pkts;
  int          cycle;
  int          limit;
  int          cursor_errs;
  int          pixel_errs;
  int          other_errs;
  int          word_cnt;
  int          idle_cycles;
  int          rx_bits;
  logic [15:0] rx_word;
  logic        sclk_q;
  logic        csn_gap;
  logic        stall_seen;
  int          final_frame;
  int          fin_x;
  int          fin_y;

  mouse_oled_top DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .ps2_clk   (ps2_clk),
    .ps2_dat   (ps2_dat),
    .cursor    (cursor),
    .oled_csn  (oled_csn),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (cycle == limit)
    begin
      $display("timeout: run did not finish within %0d cycles, %0d words seen", limit, word_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // data moves while the ps/2 clock is high
  task automatic ps2_bit(input logic b);
    ps2_dat = b;
    wait_cycles(PS2_HALF / 2);
    ps2_clk = 1'b0;
    wait_cycles(PS2_HALF);
    ps2_clk = 1'b1;
    wait_cycles(PS2_HALF / 2);
  endtask

  task automatic send_byte(input logic [7:0] data, input logic bad_parity);
    int   i;
    logic parity;
    parity = ~^data; // odd parity
    if (bad_parity)
      parity = ~parity;
    ps2_bit(1'b0);
    for (i = 0; i < 8; i++)
      ps2_bit(data[i]); // lsb first
    ps2_bit(parity);
    ps2_bit(1'b1);
    ps2_dat = 1'b1;
    wait_cycles(2 * PS2_HALF);
  endtask

  task automatic check_cursor(input string name, input int ex, input int ey, input int eb);
    if (int'(cursor.x) != ex || int'(cursor.y) != ey || int'(cursor.buttons) != eb)
    begin
      $display("CHECK FAILED %s: expected x %0d y %0d buttons %0d, actual x %0d y %0d buttons %0d",
               name, ex, ey, eb, cursor.x, cursor.y, cursor.buttons);
      cursor_errs++;
    end
  endtask

  // crosshair rule for the word at this position since reset
  task automatic check_word(input logic [15:0] w);
    int          idx;
    int          px;
    int          py;
    int          cx;
    int          cy;
    logic [15:0] exp;
    idx = word_cnt % FRAME_WORDS;
    px  = idx % `SCREEN_W;
    py  = idx / `SCREEN_W;
    cx  = -1;
    cy  = -1;
    if (word_cnt < FRAME_WORDS)
    begin
      cx = `CURSOR_X0;
      cy = `CURSOR_Y0;
    end
    else if (word_cnt >= final_frame && word_cnt < final_frame + FRAME_WORDS)
    begin
      cx = fin_x;
      cy = fin_y;
    end
    exp = (px == cx || py == cy) ? 16'hffff : 16'h0000;
    if (cx >= 0 && w != exp)
    begin
      $display("CHECK FAILED pixel word %0d (x %0d y %0d): expected %h actual %h",
               word_cnt, px, py, exp, w);
      pixel_errs++;
    end
  endtask

  // spi decoder runs on the falling clk edge between output updates
  always @(negedge clk)
  begin
    if (!arst_n)
    begin
      sclk_q      = 1'b0;
      rx_bits     = 0;
      idle_cycles = 0;
      csn_gap     = 1'b1;
    end
    else
    begin
      idle_cycles++;
      if (oled_csn)
      begin
        rx_bits = 0;
        csn_gap = 1'b1;
      end
      else if (oled_clk && !sclk_q) // panel samples on the rising edge
      begin
        if (rx_bits == 0 && !csn_gap)
        begin
          $display("csn stayed low between spi word %0d and the next one", word_cnt);
          other_errs++;
        end
        csn_gap = 1'b0;
        rx_word = {rx_word[14:0], oled_mosi};
        rx_bits++;
        if (rx_bits == 16)
        begin
          check_word(rx_word);
          word_cnt++;
          rx_bits     = 0;
          idle_cycles = 0;
        end
      end
      sclk_q = oled_clk;
      if (idle_cycles > STALL_LIMIT && !stall_seen)
      begin
        $display("stall: no spi word for %0d cycles after word %0d", STALL_LIMIT, word_cnt);
        stall_seen = 1'b1;
        other_errs++;
      end
    end
  end

  initial
  begin
    int      p;
    int      base;
    int      flag;
    packet_u pkt;
    arst_n      = 1'b0;
    ps2_clk     = 1'b1;
    ps2_dat     = 1'b1;
    cycle       = 0;
    cursor_errs = 0;
    pixel_errs  = 0;
    other_errs  = 0;
    word_cnt    = 0;
    stall_seen  = 1'b0;
    final_frame = 32'h7fff_ffff;
    fin_x       = `CURSOR_X0;
    fin_y       = `CURSOR_Y0;
    for (p = 0; p < MAX_PKTS; p++)
      trace_mem[p*COLS+3] = 8'hff; // marks rows the file leaves empty since no flag is this large
    $readmemh("tests/mouse_trace.txt", trace_mem);
    n_pkts = 0;
    while (n_pkts < MAX_PKTS && trace_mem[n_pkts*COLS+3] != 8'hff)
      n_pkts++;
    if (n_pkts == 0)
    begin
      $display("trace file holds no packets");
      other_errs++;
    end
    limit = n_pkts * PKT_BUDGET + 2 * FRAME_WORDS * WORD_CYCLES + 1000;

    wait_cycles(5);
    arst_n = 1'b1;
    wait_cycles(2);
    check_cursor("reset", `CURSOR_X0, `CURSOR_Y0, 0);

    for (p = 0; p < n_pkts; p++)
    begin
      base  = p * COLS;
      flag  = int'(trace_mem[base+3]);
      pkt.b = {trace_mem[base], trace_mem[base+1], trace_mem[base+2]};
      if (flag == 2)
        send_byte(STRAY_BYTE, 1'b0);
      send_byte(pkt.b[0], 1'b0);
      send_byte(pkt.b[1], 1'b0);
      send_byte(pkt.b[2], flag == 1); // parity hit on the last byte drops the packet
      wait_cycles(50);
      fin_x = int'(trace_mem[base+4]);
      fin_y = int'(trace_mem[base+5]);
      check_cursor($sformatf("packet %0d", p), fin_x, fin_y, int'(trace_mem[base+6]));
    end

    // first frame whose origin is issued after the last packet
    final_frame = ((word_cnt + 4) / FRAME_WORDS + 1) * FRAME_WORDS;
    while (word_cnt < final_frame + FRAME_WORDS)
      wait_cycles(1);
    if (n_pkts > 0)
      check_cursor("hold", fin_x, fin_y, int'(trace_mem[(n_pkts-1)*COLS+6]));

    $display("errors %0d: cursor %0d, pixel %0d, other %0d, spi words %0d",
             cursor_errs + pixel_errs + other_errs, cursor_errs, pixel_errs, other_errs,
             word_cnt);
    if (cursor_errs + pixel_errs + other_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: hw/mouse_oled_top.sv
`timescale 1ns/10ps

module mouse_oled_top
  import mouse_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    ps2_clk,
  input  logic    ps2_dat,
  output cursor_t cursor,
  output logic    oled_csn,
  output logic    oled_clk,
  output logic    oled_mosi
);

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       rx_error;
  pixel_t     pixel;
  logic       pix_valid;
  logic       credit;

  // mouse side
  ps2_rx u_ps2_rx (
    .clk      (clk),
    .arst_n   (arst_n),
    .ps2_clk  (ps2_clk),
    .ps2_dat  (ps2_dat),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_error (rx_error)
  );

  mouse_packet u_mouse_packet (
    .clk      (clk),
    .arst_n   (arst_n),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_error (rx_error),
    .cursor   (cursor)
  );

  // display side, paced by credits
  pixel_scan u_pixel_scan (
    .clk       (clk),
    .arst_n    (arst_n),
    .cursor    (cursor),
    .credit    (credit),
    .pixel     (pixel),
    .pix_valid (pix_valid)
  );

  oled_spi u_oled_spi (
    .clk       (clk),
    .arst_n    (arst_n),
    .pixel     (pixel),
    .pix_valid (pix_valid),
    .credit    (credit),
    .oled_csn  (oled_csn),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi)
  );

endmodule

// File: oled/oled_spi.sv
`timescale 1ns/10ps
`include "mouse_consts.svh"

module oled_spi
  import mouse_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  pixel_t pixel,
  input  logic   pix_valid,
  output logic   credit,
  output logic   oled_csn,
  output logic   oled_clk,
  output logic   oled_mosi
);

  localparam int DEPTH = `SPI_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  pixel_t        mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          load;
  logic          busy;    // a word is on the wire
  logic          phase;   // high half of the spi bit
  logic [3:0]    bit_cnt;
  pixel_t        sr;

  assign load = !busy && count != '0;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (pix_valid)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (load)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(pix_valid) - CW'(load);
    end
  end

  always_ff @(posedge clk)
  begin
    if (pix_valid)
      mem[wr_ptr] <= pixel;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy    <= 1'b0;
      phase   <= 1'b0;
      bit_cnt <= '0;
      credit  <= 1'b0;
    end
    else
    begin
      credit <= load; // slot freed
      if (load)
      begin
        busy    <= 1'b1;
        phase   <= 1'b0;
        bit_cnt <= '0;
      end
      else if (busy)
      begin
        phase <= ~phase;
        if (phase)
        begin
          bit_cnt <= bit_cnt + 4'd1;
          if (bit_cnt == 4'd15)
            busy <= 1'b0; // csn goes high for at least one cycle
        end
      end
    end
  end

  // msb first, next bit shows up as sclk falls
  always_ff @(posedge clk)
  begin
    if (load)
      sr <= mem[rd_ptr];
    else if (busy && phase)
      sr <= {sr[14:0], 1'b0};
  end

  assign oled_csn  = ~busy;
  assign oled_clk  = busy & phase;
  assign oled_mosi = busy & sr[15];

  // the credit loop must keep the scanner from overrunning the buffer
  fifo_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    pix_valid |-> count != CW'(DEPTH));

endmodule

// File: oled/pixel_scan.sv
`timescale 1ns/10ps
`include "mouse_consts.svh"

module pixel_scan
  import mouse_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  cursor_t cursor,
  input  logic    credit,
  output pixel_t  pixel,
  output logic    pix_valid
);

  localparam int CW = $clog2(`SPI_DEPTH + 1);

  logic [CW-1:0] credits;
  logic [CW-1:0] credits_nx;
  logic          issue;
  logic [6:0]    x;
  logic [5:0]    y;
  logic [6:0]    lat_x;
  logic [5:0]    lat_y;
  logic          origin;
  logic [6:0]    hair_x;
  logic [5:0]    hair_y;

  // the word on the output now has already spent its credit
  assign credits_nx = credits - CW'(pix_valid) + CW'(credit);
  assign issue      = credits_nx != '0;

  assign origin = x == 7'd0 && y == 6'd0;
  assign hair_x = origin ? cursor.x : lat_x; // new frame sees the live cursor
  assign hair_y = origin ? cursor.y : lat_y;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      credits   <= CW'(`SPI_DEPTH);
      pix_valid <= 1'b0;
      x         <= '0;
      y         <= '0;
    end
    else
    begin
      credits   <= credits_nx;
      pix_valid <= issue;
      if (issue)
      begin
        if (x == 7'(`SCREEN_W - 1))
        begin
          x <= '0;
          y <= (y == 6'(`SCREEN_H - 1)) ? 6'd0 : y + 6'd1;
        end
        else
          x <= x + 7'd1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue && origin)
    begin
      lat_x <= cursor.x;
      lat_y <= cursor.y;
    end
    if (issue)
      pixel <= (x == hair_x || y == hair_y) ? '1 : '0;
  end

  // a returned credit that was never spent would let a pixel out unpaid
  credit_held: assert property (@(posedge clk) disable iff (!arst_n)
    credits <= CW'(`SPI_DEPTH));

endmodule

// File: ps2/mouse_packet.sv
`timescale 1ns/10ps
`include "mouse_consts.svh"

module mouse_packet
  import mouse_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  input  logic       rx_error,
  output cursor_t    cursor
);

  logic [1:0]        byte_cnt;
  logic [7:0]        hold_st;
  logic [7:0]        hold_dx;
  packet_u           pkt;
  status_t           first;
  logic              last;
  logic signed [9:0] dx_ext;
  logic signed [9:0] dy_ext;
  logic signed [9:0] nx;
  logic signed [9:0] ny;
  logic [6:0]        x_new;
  logic [5:0]        y_new;

  // third byte taken straight off the receiver
  always_comb
  begin
    pkt.b = {hold_st, hold_dx, rx_byte};
  end

  assign first = status_t'(rx_byte);
  assign last  = rx_valid && byte_cnt == 2'd2;

  assign dx_ext = {{2{pkt.f.st.x_sign}}, pkt.f.dx};
  assign dy_ext = {{2{pkt.f.st.y_sign}}, pkt.f.dy};
  assign nx     = $signed({3'b000, cursor.x}) + dx_ext;
  assign ny     = $signed({4'b0000, cursor.y}) - dy_ext; // screen y grows down

  always_comb
  begin
    if (pkt.f.st.x_ovf)
      x_new = cursor.x;
    else if (nx < 0)
      x_new = '0;
    else if (nx > $signed(10'(`SCREEN_W - 1)))
      x_new = 7'(`SCREEN_W - 1);
    else
      x_new = nx[6:0];

    if (pkt.f.st.y_ovf)
      y_new = cursor.y;
    else if (ny < 0)
      y_new = '0;
    else if (ny > $signed(10'(`SCREEN_H - 1)))
      y_new = 6'(`SCREEN_H - 1);
    else
      y_new = ny[5:0];
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      byte_cnt <= '0;
    else if (rx_error)
      byte_cnt <= '0; // start over
    else if (rx_valid)
    begin
      if (byte_cnt == 2'd0 && !first.sync)
        byte_cnt <= '0; // not a status byte, keep hunting
      else if (byte_cnt == 2'd2)
        byte_cnt <= '0;
      else
        byte_cnt <= byte_cnt + 2'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_valid && byte_cnt == 2'd0)
      hold_st <= rx_byte;
    if (rx_valid && byte_cnt == 2'd1)
      hold_dx <= rx_byte;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cursor.x       <= 7'(`CURSOR_X0);
      cursor.y       <= 6'(`CURSOR_Y0);
      cursor.buttons <= '0;
    end
    else if (last && !rx_error)
    begin
      cursor.x       <= x_new;
      cursor.y       <= y_new;
      cursor.buttons <= {pkt.f.st.middle, pkt.f.st.right, pkt.f.st.left};
    end
  end

  cursor_on_screen: assert property (@(posedge clk) disable iff (!arst_n)
    int'(cursor.x) < `SCREEN_W && int'(cursor.y) < `SCREEN_H);

endmodule

// File: ps2/ps2_rx.sv
`timescale 1ns/10ps
`include "mouse_consts.svh"

module ps2_rx (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_dat,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       rx_error
);

  localparam int unsigned TO_W = $clog2(`PS2_TIMEOUT) + 1;

  logic [1:0]      clk_sync;
  logic [1:0]      dat_sync;
  logic            clk_prev;
  logic            fall;
  logic [3:0]      bit_cnt;    // bits received so far in this frame
  logic [9:0]      shift;      // start, 8 data, parity
  logic [TO_W-1:0] idle_cnt;
  logic            frame_ok;

  // both lines idle high
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
    end
    else
    begin
      clk_sync <= {clk_sync[0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_dat};
      clk_prev <= clk_sync[1];
    end
  end

  assign fall = clk_prev & ~clk_sync[1];

  // start low, odd parity over data and parity bit, stop high
  assign frame_ok = ~shift[0] & (^shift[9:1]) & dat_sync[1];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt  <= '0;
      idle_cnt <= '0;
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      rx_error <= 1'b0;
      if (fall)
      begin
        idle_cnt <= '0;
        if (bit_cnt == 4'd10) // stop bit
        begin
          bit_cnt  <= '0;
          rx_valid <= frame_ok;
          rx_error <= ~frame_ok;
        end
        else
          bit_cnt <= bit_cnt + 4'd1;
      end
      else if (bit_cnt != 4'd0)
      begin
        if (idle_cnt == TO_W'(`PS2_TIMEOUT - 1))
        begin
          bit_cnt  <= '0; // give up on the partial frame
          idle_cnt <= '0;
          rx_error <= 1'b1;
        end
        else
          idle_cnt <= idle_cnt + TO_W'(1);
      end
      else
        idle_cnt <= '0;
    end
  end

  // lsb first, so bits enter at the top
  always_ff @(posedge clk)
  begin
    if (fall && bit_cnt != 4'd10)
      shift <= {dat_sync[1], shift[9:1]};
    if (fall && bit_cnt == 4'd10)
      rx_byte <= shift[8:1];
  end

  rx_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(rx_valid && rx_error));

endmodule

// File: common/mouse_pkg.sv
package mouse_pkg;

  // first byte of a stream-mode packet, bit 7 down to bit 0
  typedef struct packed {
    logic y_ovf;
    logic x_ovf;
    logic y_sign;
    logic x_sign;
    logic sync;    // always one in a real first byte
    logic middle;
    logic right;
    logic left;
  } status_t;

  typedef struct packed {
    status_t    st;
    logic [7:0] dx;   // low bits, sign sits in st
    logic [7:0] dy;
  } packet_f_t;

  // same 24 bits, filled byte by byte, read as fields
  typedef union packed {
    logic [0:2][7:0] b;   // b[0] is the status byte
    packet_f_t       f;
  } packet_u;

  typedef struct packed {
    logic [6:0] x;
    logic [5:0] y;
    logic [2:0] buttons;  // {middle, right, left}
  } cursor_t;

  typedef logic [15:0] pixel_t;  // rgb565

endpackage

// File: common/mouse_consts.svh
`ifndef MOUSE_CONSTS_SVH
`define MOUSE_CONSTS_SVH

// panel size in pixels
`define SCREEN_W 96
`define SCREEN_H 64

// clk cycles without a ps/2 clock edge before a partial frame is dropped
`define PS2_TIMEOUT 4096

// oled_spi buffer depth, also the credits pixel_scan starts with
`define SPI_DEPTH 2

// cursor position out of reset
`define CURSOR_X0 48
`define CURSOR_Y0 32

`endif
